// ==== src/coreinfo_pkg.sv ====
// Shared definitions for the core-information register block.
// Holds the AXI channel structs, the state and opcode enums,
// the register word map and the table of cores in the system.

package coreinfo_pkg;

	localparam int ID_W = 4;
	localparam int LEN_W = 4;
	localparam int N_CORES = 2;

	// Core n answers on AXI ID CORE_AXI_ID[n] and identifies as CORE_ID[n].
	localparam logic [31:0] CORE_AXI_ID [N_CORES] = '{32'h0000_0001, 32'h0000_0002};
	localparam logic [31:0] CORE_ID [N_CORES] = '{32'h0000_0000, 32'h0000_0001};

	// Returned for a read from an AXI ID that belongs to no core.
	localparam logic [31:0] NO_CORE_ID = 32'hFFFF_FFFF;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Word index, taken from byte address bits 3:2.
	typedef enum logic [1:0] {
		ADDR_N_CORES = 2'd0,
		ADDR_CORE_ID = 2'd1,
		ADDR_SET_RST = 2'd2,
		ADDR_CLR_RST = 2'd3
	} word_addr_e;

	typedef enum logic [1:0] {RD_IDLE, RD_PREP, RD_BEAT} rd_state_e;
	typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
	typedef enum logic [1:0] {OP_NONE, OP_SET_RST, OP_CLR_RST} reg_op_e;

	typedef struct packed {
		logic             valid;
		logic [ID_W-1:0]  id;
		logic [31:0]      addr;
		logic [LEN_W-1:0] len;
	} ar_chan_t;

	typedef struct packed {
		logic            valid;
		logic [ID_W-1:0] id;
		logic [31:0]     data;
		logic [1:0]      resp;
		logic            last;
	} r_chan_t;

	typedef struct packed {
		logic            valid;
		logic [ID_W-1:0] id;
		logic [31:0]     addr;
	} aw_chan_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic        last;
	} w_chan_t;

	typedef struct packed {
		logic            valid;
		logic [ID_W-1:0] id;
		logic [1:0]      resp;
	} b_chan_t;

	// Word and AXI ID of the read in progress.
	typedef struct packed {
		word_addr_e      word;
		logic [ID_W-1:0] id;
	} rd_query_t;

	typedef struct packed {
		reg_op_e     op;
		logic [31:0] data;
	} reg_cmd_t;

	// Bit k is the active-low reset of core k; core 0 has none.
	typedef logic [N_CORES-1:1] core_rst_t;

endpackage

// ==== src/coreinfo_read.sv ====
// Read channel engine.
// Accepts one AR request at a time, waits one cycle for the register
// decode to settle, then returns len+1 beats of the same word.

module coreinfo_read (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  coreinfo_pkg::ar_chan_t ar,
	output logic                   arready,
	input  logic                   rready,
	output coreinfo_pkg::r_chan_t  r,
	output coreinfo_pkg::rd_query_t rd_query,
	input  logic [31:0]            rd_data
);

	import coreinfo_pkg::*;

	rd_state_e        state;
	logic [LEN_W-1:0] beat_cnt;
	logic [LEN_W-1:0] len_q;
	logic [ID_W-1:0]  id_q;
	word_addr_e       word_q;
	logic             ar_hs;
	logic             r_hs;

	assign arready = (state == RD_IDLE);
	assign ar_hs = ar.valid && arready;
	assign r_hs = r.valid && rready;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= RD_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (ar_hs) begin
						beat_cnt <= '0;
						state <= RD_PREP;
					end
				end
				// One cycle for the query to reach the register unit.
				RD_PREP: state <= RD_BEAT;
				RD_BEAT: begin
					if (r_hs) begin
						if (r.last) begin
							state <= RD_IDLE;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// Request fields only change while the engine is idle.
	always_ff @(posedge clk_i) begin
		if (ar_hs) begin
			id_q <= ar.id;
			len_q <= ar.len;
			word_q <= word_addr_e'(ar.addr[3:2]);
		end
	end

	assign rd_query.word = word_q;
	assign rd_query.id = id_q;

	// Every beat carries the same decoded word.
	assign r.valid = (state == RD_BEAT);
	assign r.id = id_q;
	assign r.data = rd_data;
	assign r.resp = RESP_OKAY;
	assign r.last = (state == RD_BEAT) && (beat_cnt == len_q);

endmodule

// ==== src/coreinfo_write.sv ====
// Write channel engine.
// Latches the AW request, turns each accepted W beat into a register
// command and answers with one B response after the last beat.

module coreinfo_write (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  coreinfo_pkg::aw_chan_t aw,
	output logic                   awready,
	input  coreinfo_pkg::w_chan_t  w,
	output logic                   wready,
	output coreinfo_pkg::b_chan_t  b,
	input  logic                   bready,
	output coreinfo_pkg::reg_cmd_t reg_cmd
);

	import coreinfo_pkg::*;

	wr_state_e       state;
	logic [ID_W-1:0] id_q;
	word_addr_e      word_q;
	logic            aw_hs;
	logic            w_hs;
	logic            b_hs;

	assign awready = (state == WR_ADDR);
	assign wready = (state == WR_DATA);
	assign aw_hs = aw.valid && awready;
	assign w_hs = w.valid && wready;
	assign b_hs = b.valid && bready;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= WR_ADDR;
		end else begin
			case (state)
				WR_ADDR: begin
					if (aw_hs) begin
						state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_hs && w.last) begin
						state <= WR_RESP;
					end
				end
				// A pending response blocks the next address.
				WR_RESP: begin
					if (b_hs) begin
						state <= WR_ADDR;
					end
				end
				default: state <= WR_ADDR;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (aw_hs) begin
			id_q <= aw.id;
			word_q <= word_addr_e'(aw.addr[3:2]);
		end
	end

	// The command is valid only in the cycle of the W handshake.
	always_comb begin
		reg_cmd.op = OP_NONE;
		reg_cmd.data = w.data;
		if (w_hs) begin
			case (word_q)
				ADDR_SET_RST: reg_cmd.op = OP_SET_RST;
				ADDR_CLR_RST: reg_cmd.op = OP_CLR_RST;
				default: reg_cmd.op = OP_NONE;
			endcase
		end
	end

	assign b.valid = (state == WR_RESP);
	assign b.id = id_q;
	assign b.resp = RESP_OKAY;

endmodule

// ==== src/coreinfo_regs.sv ====
// Register unit.
// Decodes the read word, maps the AXI ID of a read to a core ID and
// keeps the per-core reset register that writes set and clear.

module coreinfo_regs (
	input  logic                    clk_i,
	input  logic                    rst_n,
	input  coreinfo_pkg::rd_query_t rd_query,
	output logic [31:0]             rd_data,
	input  coreinfo_pkg::reg_cmd_t  reg_cmd,
	output coreinfo_pkg::core_rst_t core_rst
);

	import coreinfo_pkg::*;

	logic [31:0] axi_id_ext;
	logic [31:0] core_id;

	assign axi_id_ext = {{(32 - ID_W){1'b0}}, rd_query.id};

	// Unknown AXI IDs fall through to NO_CORE_ID.
	always_comb begin
		core_id = NO_CORE_ID;
		for (int k = 0; k < N_CORES; k++) begin
			if (axi_id_ext == CORE_AXI_ID[k]) begin
				core_id = CORE_ID[k];
			end
		end
	end

	always_comb begin
		case (rd_query.word)
			ADDR_N_CORES: rd_data = 32'(N_CORES);
			ADDR_CORE_ID: rd_data = core_id;
			default: rd_data = '0;
		endcase
	end

	// Core 0 is never put in reset, so the loop starts at core 1.
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			core_rst <= '0;
		end else begin
			for (int k = 1; k < N_CORES; k++) begin
				if (reg_cmd.data == CORE_ID[k]) begin
					if (reg_cmd.op == OP_SET_RST) begin
						core_rst[k] <= 1'b0;
					end else if (reg_cmd.op == OP_CLR_RST) begin
						core_rst[k] <= 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== src/coreinfo_top.sv ====
// Top level of the core-information block.
// Connects the read engine, the write engine and the register unit.

module coreinfo_top (
	input  logic                    clk_i,
	input  logic                    rst_n,
	input  coreinfo_pkg::ar_chan_t  ar,
	output logic                    arready,
	output coreinfo_pkg::r_chan_t   r,
	input  logic                    rready,
	input  coreinfo_pkg::aw_chan_t  aw,
	output logic                    awready,
	input  coreinfo_pkg::w_chan_t   w,
	output logic                    wready,
	output coreinfo_pkg::b_chan_t   b,
	input  logic                    bready,
	output coreinfo_pkg::core_rst_t core_rst
);

	import coreinfo_pkg::*;

	rd_query_t   rd_query;
	logic [31:0] rd_data;
	reg_cmd_t    reg_cmd;

	coreinfo_read read_i (
		.clk_i    (clk_i),
		.rst_n    (rst_n),
		.ar       (ar),
		.arready  (arready),
		.rready   (rready),
		.r        (r),
		.rd_query (rd_query),
		.rd_data  (rd_data)
	);

	coreinfo_write write_i (
		.clk_i   (clk_i),
		.rst_n   (rst_n),
		.aw      (aw),
		.awready (awready),
		.w       (w),
		.wready  (wready),
		.b       (b),
		.bready  (bready),
		.reg_cmd (reg_cmd)
	);

	coreinfo_regs regs_i (
		.clk_i    (clk_i),
		.rst_n    (rst_n),
		.rd_query (rd_query),
		.rd_data  (rd_data),
		.reg_cmd  (reg_cmd),
		.core_rst (core_rst)
	);

endmodule

// ==== tb/coreinfo_props.sv ====
// Concurrent assertions for the core-information block.
// Covers valid/ready stability on all five channels, the read
// latency from AR to the first R beat and the reset value of core_rst.

module coreinfo_props (
	input logic                     clk_i,
	input logic                     rst_n,
	input coreinfo_pkg::ar_chan_t   ar,
	input logic                     arready,
	input coreinfo_pkg::r_chan_t    r,
	input logic                     rready,
	input coreinfo_pkg::aw_chan_t   aw,
	input logic                     awready,
	input coreinfo_pkg::w_chan_t    w,
	input logic                     wready,
	input coreinfo_pkg::b_chan_t    b,
	input logic                     bready,
	input coreinfo_pkg::core_rst_t  core_rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed assertions, read by the testbench summary.
	int unsigned fail_cnt = 0;

	ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		ar.valid && !arready |=> ar.valid && $stable(ar))
		else begin
			fail_cnt++;
			$error("AR request changed or dropped before its handshake");
		end

	r_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		r.valid && !rready |=> r.valid && $stable(r))
		else begin
			fail_cnt++;
			$error("R beat changed or dropped while stalled");
		end

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		aw.valid && !awready |=> aw.valid && $stable(aw))
		else begin
			fail_cnt++;
			$error("AW request changed or dropped before its handshake");
		end

	w_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		w.valid && !wready |=> w.valid && $stable(w))
		else begin
			fail_cnt++;
			$error("W beat changed or dropped before its handshake");
		end

	b_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		b.valid && !bready |=> b.valid && $stable(b))
		else begin
			fail_cnt++;
			$error("B response changed or dropped while stalled");
		end

	// The first beat shows up two edges after the AR handshake.
	r_latency: assert property (@(posedge clk_i) disable iff (!rst_n)
		$past(ar.valid && arready, 2) |-> r.valid && !$past(r.valid))
		else begin
			fail_cnt++;
			$error("First R beat did not follow the AR handshake by two cycles");
		end

	rst_value: assert property (@(posedge clk_i)
		$rose(rst_n) |-> core_rst == '0)
		else begin
			fail_cnt++;
			$error("core_rst was not all low after reset");
		end

endmodule

bind coreinfo_top coreinfo_props props_i (.*);

// ==== tb/coreinfo_tb.sv ====
// Testbench for the core-information block.
// Loads transactions from the stim file and runs the reads and the
// writes as two parallel streams with random rready and bready stalls.
// Checks every R beat, every B response, core_rst after each W beat
// and the ready and valid flags of the handshakes.

module coreinfo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import coreinfo_pkg::*;

	typedef struct packed {
		logic [15:0]      num;
		logic [ID_W-1:0]  id;
		logic [1:0]       word;
		logic [LEN_W-1:0] len;
		logic [31:0]      wdata;
		logic [31:0]      expv;
	} test_t;

	logic      clk_i;
	logic      rst_n;
	ar_chan_t  ar;
	logic      arready;
	r_chan_t   r;
	logic      rready;
	aw_chan_t  aw;
	logic      awready;
	w_chan_t   w;
	logic      wready;
	b_chan_t   b;
	logic      bready;
	core_rst_t core_rst;

	test_t       rd_q[$];
	test_t       wr_q[$];
	int          n_lines;
	int          n_checks;
	int          n_errors;
	logic        loaded;
	logic [31:0] rd_lfsr;
	logic [31:0] wr_lfsr;

	coreinfo_top dut_i (.*);

	always #50 clk_i = ~clk_i;

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic check_r(input r_chan_t got, input r_chan_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: R id %h data %h resp %b last %b, expected id %h data %h last %b",
				$time, got.id, got.data, got.resp, got.last, exp.id, exp.data, exp.last);
		end
	endtask

	task automatic check_b(input b_chan_t got, input b_chan_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: B response id %h resp %b, expected id %h resp %b",
				$time, got.id, got.resp, exp.id, exp.resp);
		end
	endtask

	task automatic check_rst(input core_rst_t got, input core_rst_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: core_rst is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic load_stim();
		int          fd;
		int          n;
		string       kind;
		string       rest;
		logic [31:0] f_id;
		logic [31:0] f_word;
		logic [31:0] f_len;
		logic [31:0] f_wdata;
		logic [31:0] f_exp;
		test_t       t;
		fd = $fopen("tb/coreinfo_stim.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("Could not open the stim file tb/coreinfo_stim.txt");
			return;
		end
		while ($fscanf(fd, " %s", kind) == 1) begin
			if (kind[0] == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, " %h %h %h %h %h", f_id, f_word, f_len, f_wdata, f_exp);
				n_lines++;
				t = '{num: 16'(n_lines), id: f_id[ID_W-1:0], word: f_word[1:0],
					len: f_len[LEN_W-1:0], wdata: f_wdata, expv: f_exp};
				if (n != 5) begin
					n_errors++;
					$display("Stim line %0d is incomplete and was skipped", n_lines);
				end else if (kind == "W") begin
					wr_q.push_back(t);
				end else begin
					rd_q.push_back(t);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_read(input test_t t);
		int errs;
		int beat;
		errs = n_errors;
		beat = 0;
		@(posedge clk_i);
		ar <= '{valid: 1'b1, id: t.id, addr: {28'd0, t.word, 2'b00}, len: t.len};
		do @(negedge clk_i); while (!arready);
		@(posedge clk_i);
		ar <= '0;
		while (beat <= int'(t.len)) begin
			rready <= rd_lfsr[0];
			rd_lfsr = lfsr_step(rd_lfsr);
			@(negedge clk_i);
			// No new request is accepted while a burst is in flight.
			check_flag(arready, 1'b0, "arready");
			if (r.valid && rready) begin
				check_r(r, r_chan_t'{valid: 1'b1, id: t.id, data: t.expv, resp: RESP_OKAY,
					last: (beat == int'(t.len))});
				beat++;
			end
			@(posedge clk_i);
		end
		rready <= 1'b0;
		$display("Test %0d read id %h word %0d len %0d: %s", t.num, t.id, t.word, t.len,
			(n_errors == errs) ? "ok" : "errors");
	endtask

	task automatic run_write(input test_t t);
		int   errs;
		logic done;
		errs = n_errors;
		done = 1'b0;
		@(posedge clk_i);
		aw <= '{valid: 1'b1, id: t.id, addr: {28'd0, t.word, 2'b00}};
		do @(negedge clk_i); while (!awready);
		@(posedge clk_i);
		aw <= '0;
		for (int beat = 0; beat <= int'(t.len); beat++) begin
			w <= '{valid: 1'b1, data: t.wdata, last: (beat == int'(t.len))};
			do @(negedge clk_i); while (!wready);
			@(posedge clk_i);
			w <= '0;
			// Each accepted beat shows on core_rst one cycle later.
			@(negedge clk_i);
			check_rst(core_rst, core_rst_t'(t.expv));
			check_flag(awready, 1'b0, "awready");
			check_flag(wready, beat != int'(t.len), "wready");
			check_flag(b.valid, beat == int'(t.len), "b.valid");
			@(posedge clk_i);
		end
		while (!done) begin
			bready <= wr_lfsr[0];
			wr_lfsr = lfsr_step(wr_lfsr);
			@(negedge clk_i);
			// A pending response holds off the next address.
			check_flag(awready, 1'b0, "awready");
			if (b.valid && bready) begin
				check_b(b, b_chan_t'{valid: 1'b1, id: t.id, resp: RESP_OKAY});
				done = 1'b1;
			end
			@(posedge clk_i);
		end
		bready <= 1'b0;
		$display("Test %0d write id %h word %0d len %0d: %s", t.num, t.id, t.word, t.len,
			(n_errors == errs) ? "ok" : "errors");
	endtask

	initial begin
		clk_i = 1'b0;
		rst_n = 1'b0;
		ar = '0;
		rready = 1'b0;
		aw = '0;
		w = '0;
		bready = 1'b0;
		n_lines = 0;
		n_checks = 0;
		n_errors = 0;
		loaded = 1'b0;
		rd_lfsr = 32'h94c0c03d;
		wr_lfsr = 32'h94c0c03d;
		load_stim();
		loaded = 1'b1;
		repeat (3) @(posedge clk_i);
		rst_n <= 1'b1;
		@(negedge clk_i);
		check_rst(core_rst, '0);
		check_flag(arready, 1'b1, "arready");
		check_flag(awready, 1'b1, "awready");
		check_flag(wready, 1'b0, "wready");
		check_flag(r.valid, 1'b0, "r.valid");
		check_flag(b.valid, 1'b0, "b.valid");
		$display("Test 0 reset value: %s", (n_errors == 0) ? "ok" : "errors");
		fork
			begin
				foreach (rd_q[i]) run_read(rd_q[i]);
			end
			begin
				foreach (wr_q[i]) run_write(wr_q[i]);
			end
		join
		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			n_lines, n_checks, n_errors, dut_i.props_i.fail_cnt);
		if (n_errors == 0 && dut_i.props_i.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Allows 64 cycles per stim line plus the reset phase.
	initial begin
		wait (loaded);
		#((n_lines * 64 + 16) * 100);
		$display("Timeout: the tests did not finish within %0d clock cycles", n_lines * 64 + 16);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
src/coreinfo_pkg.sv
src/coreinfo_read.sv
src/coreinfo_write.sv
src/coreinfo_regs.sv
src/coreinfo_top.sv
tb/coreinfo_props.sv
tb/coreinfo_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = coreinfo_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass message.
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/coreinfo_stim.txt ====
# kind axi_id word len write_data expected (all hex)
# expected is the data of every R beat, or core_rst after each W beat
R 1 0 3 00000000 00000002
W 3 3 0 00000001 00000001
R 2 0 0 00000000 00000002
W 4 3 0 00000000 00000001
R 1 1 0 00000000 00000000
W 5 2 0 0000abcd 00000001
R 2 1 1 00000000 00000001
W 6 0 0 00000001 00000001
R 5 1 0 00000000 ffffffff
W 7 1 0 00000001 00000001
R 0 1 2 00000000 ffffffff
W 8 2 0 00000001 00000000
R 3 2 0 00000000 00000000
W 9 3 3 00000001 00000001
R 4 3 1 00000000 00000000
W a 2 2 00000001 00000000
R 2 1 7 00000000 00000001
W f 3 1 00000001 00000001
R 1 0 f 00000000 00000002
